/* source/histConfigPkg.sv */
package histConfigPkg;

    // pixel array
    localparam int LANE_NUM = 4;
    localparam int LANE_BITS = 2;

    // histogram geometry
    localparam int BIN_NUM = 256;
    localparam int BIN_BITS = 8;

    // per-bin counter, saturating
    localparam int COUNT_BITS = 10;
    localparam int COUNT_MAX = (1 << COUNT_BITS) - 1;

    // cycles between frame end and first readout address
    localparam int DRAIN_GAP = 2;
    localparam int GAP_BITS = $clog2(DRAIN_GAP) + 1;

    // scan counter covers all bins plus one tail cycle
    localparam int SCAN_BITS = BIN_BITS + 1;

endpackage

/* source/histTypesPkg.sv */
package histTypesPkg;

    import histConfigPkg::*;

    typedef logic [BIN_BITS-1:0] binCodeT;     // time-bin code
    typedef logic [COUNT_BITS-1:0] countT;     // bin count
    typedef logic [LANE_BITS-1:0] laneIdxT;    // pixel / lane index

    // frame sequencing in the router
    typedef enum logic [1:0] {
        RT_IDLE,
        RT_CLEARING,
        RT_ACQUIRE
    } routerStateT;

    // per-lane memory control
    typedef enum logic [1:0] {
        LN_IDLE,
        LN_CLEAR,
        LN_COUNT
    } laneStateT;

    // peak search over all lanes
    typedef enum logic [2:0] {
        RO_IDLE,
        RO_GAP,
        RO_SCAN,
        RO_REPORT,
        RO_DONE
    } readoutStateT;

endpackage

/* source/laneFeedIf.sv */
`timescale 1ns/1ps

interface laneFeedIf;

    import histTypesPkg::*;

    logic sampleStrobe;    // one sample for this lane
    binCodeT binCode;      // bin of that sample
    logic clearStart;      // start memory sweep
    logic clearing;        // high during the sweep

    modport router (
        output sampleStrobe,
        output binCode,
        output clearStart,
        input clearing
    );

    modport lane (
        input sampleStrobe,
        input binCode,
        input clearStart,
        output clearing
    );

endinterface

/* source/laneDrainIf.sv */
`timescale 1ns/1ps

interface laneDrainIf;

    import histTypesPkg::*;

    logic drainActive;     // readout owns the read port
    binCodeT drainAddr;    // bin being read
    countT drainData;      // count, one cycle after drainAddr
    logic pipeEmpty;       // no increment in flight

    modport readout (
        output drainActive,
        output drainAddr,
        input drainData,
        input pipeEmpty
    );

    modport lane (
        input drainActive,
        input drainAddr,
        output drainData,
        output pipeEmpty
    );

endinterface

/* source/binMemory.sv */
`timescale 1ns/1ps

module binMemory (
    input logic clk,
    input logic wrEn,
    input histTypesPkg::binCodeT wrAddr,
    input histTypesPkg::countT wrData,
    input histTypesPkg::binCodeT rdAddr,
    output histTypesPkg::countT rdData
);

    import histConfigPkg::*;
    import histTypesPkg::*;

    countT mem [BIN_NUM];

    // read returns the old word on a same-address write
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
        rdData <= mem[rdAddr];
    end

endmodule

/* source/sampleRouter.sv */
`timescale 1ns/1ps

module sampleRouter (
    input logic clk,
    input logic res,
    input logic frameStart,
    input logic frameEnd,
    input logic sampleValid,
    input histTypesPkg::laneIdxT samplePixel,
    input histTypesPkg::binCodeT sampleBin,
    input logic doneIn,
    output logic busy,
    output logic scanStart,
    laneFeedIf.router feed [histConfigPkg::LANE_NUM]
);

    import histConfigPkg::*;
    import histTypesPkg::*;

    routerStateT state;
    logic busyReg;
    logic frameAccept;
    logic clearQ;
    logic clearingQ;               // lane 0 clearing, one cycle late
    logic [LANE_NUM-1:0] strobeQ;
    binCodeT binQ;

    assign busy = busyReg && !doneIn;   // drops in the frameDone cycle
    assign frameAccept = frameStart && !busy;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= RT_IDLE;
            busyReg <= 1'b0;
            clearQ <= 1'b0;
            clearingQ <= 1'b0;
            scanStart <= 1'b0;
            strobeQ <= '0;
        end else begin
            clearQ <= 1'b0;
            scanStart <= 1'b0;
            clearingQ <= feed[0].clearing;
            // one-hot lane strobe, only while acquiring
            if (state == RT_ACQUIRE && sampleValid) begin
                strobeQ <= {{(LANE_NUM-1){1'b0}}, 1'b1} << samplePixel;
            end else begin
                strobeQ <= '0;
            end
            case (state)
                RT_IDLE: begin
                    if (frameAccept) begin
                        state <= RT_CLEARING;
                        clearQ <= 1'b1;
                    end
                end
                RT_CLEARING: begin
                    if (clearingQ && !feed[0].clearing) begin    // sweep just finished
                        state <= RT_ACQUIRE;
                    end
                end
                RT_ACQUIRE: begin
                    if (frameEnd) begin
                        state <= RT_IDLE;
                        scanStart <= 1'b1;
                    end
                end
                default: state <= RT_IDLE;
            endcase
            if (frameAccept) begin
                busyReg <= 1'b1;
            end else if (doneIn) begin
                busyReg <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sampleValid) begin
            binQ <= sampleBin;
        end
    end

    for (genvar i = 0; i < LANE_NUM; i++) begin : gFeed
        assign feed[i].sampleStrobe = strobeQ[i];
        assign feed[i].binCode = binQ;        // same bin to every lane
        assign feed[i].clearStart = clearQ;
    end

endmodule

/* source/histogramLane.sv */
`timescale 1ns/1ps

module histogramLane (
    input logic clk,
    input logic res,
    laneFeedIf.lane feed,
    laneDrainIf.lane drain
);

    import histConfigPkg::*;
    import histTypesPkg::*;

    laneStateT state;
    binCodeT clearAddr;

    // read stage
    logic readValid;
    binCodeT readBin;

    // write stage
    logic incWrEn;
    binCodeT incAddr;
    countT incData;

    // write retired last cycle, memory read may still miss it
    logic lastWrEn;
    binCodeT lastAddr;
    countT lastData;

    countT baseCount;
    countT nextCount;

    logic memWrEn;
    binCodeT memWrAddr;
    countT memWrData;
    binCodeT memRdAddr;
    countT memRdData;

    binMemory uMem (
        .clk(clk),
        .wrEn(memWrEn),
        .wrAddr(memWrAddr),
        .wrData(memWrData),
        .rdAddr(memRdAddr),
        .rdData(memRdData)
    );

    // newest matching value wins
    always_comb begin
        if (incWrEn && incAddr == readBin) begin
            baseCount = incData;
        end else if (lastWrEn && lastAddr == readBin) begin
            baseCount = lastData;
        end else begin
            baseCount = memRdData;
        end
        if (baseCount == countT'(COUNT_MAX)) begin
            nextCount = baseCount;                  // saturate
        end else begin
            nextCount = baseCount + countT'(1);
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= LN_IDLE;
            clearAddr <= '0;
            readValid <= 1'b0;
            incWrEn <= 1'b0;
            lastWrEn <= 1'b0;
        end else begin
            readValid <= feed.sampleStrobe && (state == LN_COUNT);
            incWrEn <= readValid;
            lastWrEn <= incWrEn;
            case (state)
                LN_IDLE, LN_COUNT: begin
                    if (feed.clearStart) begin
                        state <= LN_CLEAR;
                        clearAddr <= '0;
                    end
                end
                LN_CLEAR: begin
                    clearAddr <= clearAddr + binCodeT'(1);
                    if (clearAddr == binCodeT'(BIN_NUM - 1)) begin
                        state <= LN_COUNT;
                    end
                end
                default: state <= LN_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        readBin <= feed.binCode;
        incAddr <= readBin;
        incData <= nextCount;
        lastAddr <= incAddr;
        lastData <= incData;
    end

    // sweep owns the write port while clearing
    assign memWrEn = (state == LN_CLEAR) || incWrEn;
    assign memWrAddr = (state == LN_CLEAR) ? clearAddr : incAddr;
    assign memWrData = (state == LN_CLEAR) ? '0 : incData;
    assign memRdAddr = drain.drainActive ? drain.drainAddr : feed.binCode;

    assign feed.clearing = (state == LN_CLEAR);
    assign drain.drainData = memRdData;
    assign drain.pipeEmpty = !feed.sampleStrobe && !readValid;   // last write lands this edge

endmodule

/* source/peakReadout.sv */
`timescale 1ns/1ps

module peakReadout (
    input logic clk,
    input logic res,
    input logic scanStart,
    laneDrainIf.readout drain [histConfigPkg::LANE_NUM],
    output logic peakValid,
    output histTypesPkg::laneIdxT peakLane,
    output histTypesPkg::binCodeT peakBin,
    output histTypesPkg::countT peakCount,
    output logic frameDone
);

    import histConfigPkg::*;
    import histTypesPkg::*;

    readoutStateT state;
    logic [GAP_BITS-1:0] gapCnt;
    logic [SCAN_BITS-1:0] scanCnt;  // BIN_NUM addresses plus one tail cycle
    laneIdxT laneCnt;
    logic cmpValid;                 // drainData holds bin cmpBin
    binCodeT cmpBin;
    binCodeT bestBin;
    countT bestCount;
    countT laneData [LANE_NUM];
    logic [LANE_NUM-1:0] laneEmpty;

    for (genvar i = 0; i < LANE_NUM; i++) begin : gDrain
        assign drain[i].drainActive = (state == RO_SCAN) && (laneCnt == laneIdxT'(i));
        assign drain[i].drainAddr = scanCnt[BIN_BITS-1:0];
        assign laneData[i] = drain[i].drainData;
        assign laneEmpty[i] = drain[i].pipeEmpty;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= RO_IDLE;
            gapCnt <= '0;
            scanCnt <= '0;
            laneCnt <= '0;
            cmpValid <= 1'b0;
        end else begin
            cmpValid <= (state == RO_SCAN) && (scanCnt != SCAN_BITS'(BIN_NUM));
            case (state)
                RO_IDLE: begin
                    if (scanStart) begin
                        state <= RO_GAP;
                        gapCnt <= '0;
                        laneCnt <= '0;
                    end
                end
                RO_GAP: begin
                    if (gapCnt == GAP_BITS'(DRAIN_GAP - 1)) begin
                        if (&laneEmpty) begin    // hold until every lane has drained
                            state <= RO_SCAN;
                            scanCnt <= '0;
                        end
                    end else begin
                        gapCnt <= gapCnt + 1'b1;
                    end
                end
                RO_SCAN: begin
                    if (scanCnt == SCAN_BITS'(BIN_NUM)) begin
                        state <= RO_REPORT;
                    end else begin
                        scanCnt <= scanCnt + 1'b1;
                    end
                end
                RO_REPORT: begin
                    scanCnt <= '0;
                    if (laneCnt == laneIdxT'(LANE_NUM - 1)) begin
                        state <= RO_DONE;
                    end else begin
                        laneCnt <= laneCnt + 1'b1;
                        state <= RO_SCAN;
                    end
                end
                RO_DONE: state <= RO_IDLE;
                default: state <= RO_IDLE;
            endcase
        end
    end

    // strictly greater, so the lowest bin keeps a tie
    always_ff @(posedge clk) begin
        cmpBin <= scanCnt[BIN_BITS-1:0];
        if (state == RO_GAP || state == RO_REPORT) begin
            bestCount <= '0;
            bestBin <= '0;
        end else if (cmpValid && laneData[laneCnt] > bestCount) begin
            bestCount <= laneData[laneCnt];
            bestBin <= cmpBin;
        end
    end

    assign peakValid = (state == RO_REPORT);
    assign peakLane = laneCnt;
    assign peakBin = bestBin;
    assign peakCount = bestCount;
    assign frameDone = (state == RO_DONE);

endmodule

/* source/histogramTop.sv */
`timescale 1ns/1ps

module histogramTop (
    input logic clk,
    input logic res,
    input logic frameStart,
    input logic frameEnd,
    input logic sampleValid,
    input histTypesPkg::laneIdxT samplePixel,
    input histTypesPkg::binCodeT sampleBin,
    output logic busy,
    output logic peakValid,
    output histTypesPkg::laneIdxT peakLane,
    output histTypesPkg::binCodeT peakBin,
    output histTypesPkg::countT peakCount,
    output logic frameDone
);

    import histConfigPkg::*;

    logic scanStart;

    laneFeedIf feedBus [LANE_NUM] ();
    laneDrainIf drainBus [LANE_NUM] ();

    sampleRouter uRouter (
        .clk(clk),
        .res(res),
        .frameStart(frameStart),
        .frameEnd(frameEnd),
        .sampleValid(sampleValid),
        .samplePixel(samplePixel),
        .sampleBin(sampleBin),
        .doneIn(frameDone),
        .busy(busy),
        .scanStart(scanStart),
        .feed(feedBus)
    );

    // one histogram per pixel
    for (genvar i = 0; i < LANE_NUM; i++) begin : gLane
        histogramLane uLane (
            .clk(clk),
            .res(res),
            .feed(feedBus[i]),
            .drain(drainBus[i])
        );
    end

    peakReadout uReadout (
        .clk(clk),
        .res(res),
        .scanStart(scanStart),
        .drain(drainBus),
        .peakValid(peakValid),
        .peakLane(peakLane),
        .peakBin(peakBin),
        .peakCount(peakCount),
        .frameDone(frameDone)
    );

endmodule

/* bench/histogramBench.sv */
`timescale 1ns/1ps

module histogramBench;

    import histConfigPkg::*;
    import histTypesPkg::*;

    logic clk = 1'b0;
    logic res;
    logic frameStart;
    logic frameEnd;
    logic sampleValid;
    laneIdxT samplePixel;
    binCodeT sampleBin;
    logic busy;
    logic peakValid;
    laneIdxT peakLane;
    binCodeT peakBin;
    countT peakCount;
    logic frameDone;

    int modelCount [LANE_NUM][BIN_NUM];    // reference histograms
    laneIdxT gotLane [$];
    binCodeT gotBin [$];
    countT gotCount [$];
    int doneCount = 0;
    int cycle = 0;
    int lastPeakCycle = 0;

    histogramTop u_histogramTop (.*);

    always #10 clk = ~clk;

    task automatic failNow(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic checkFlag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            failNow($sformatf("** Error at %0d ns: %s is %b, expected %b",
                $time, what, got, exp));
        end
    endtask

    task automatic checkPeak(input laneIdxT gotL, input binCodeT gotB, input countT gotC,
                             input laneIdxT expL, input binCodeT expB, input countT expC);
        if (gotL !== expL || gotB !== expB || gotC !== expC) begin
            failNow($sformatf(
                "** Error at %0d ns: peak lane %0d bin %0d count %0d, expected %0d %0d %0d",
                $time, gotL, gotB, gotC, expL, expB, expC));
        end
    endtask

    task automatic addToModel(input laneIdxT pix, input binCodeT bin);
        if (modelCount[pix][bin] < COUNT_MAX) begin
            modelCount[pix][bin]++;    // counts stick at the top
        end
    endtask

    task automatic findPeak(input int lane, output binCodeT bin, output countT count);
        int best;
        best = 0;
        bin = '0;
        for (int b = 0; b < BIN_NUM; b++) begin
            if (modelCount[lane][b] > best) begin    // lowest bin keeps a tie
                best = modelCount[lane][b];
                bin = binCodeT'(b);
            end
        end
        count = countT'(best);
    endtask

    task automatic driveInputs(input logic fs, input logic fe, input logic sv,
                               input laneIdxT pix, input binCodeT bin);
        @(posedge clk);
        frameStart <= fs;
        frameEnd <= fe;
        sampleValid <= sv;
        samplePixel <= pix;
        sampleBin <= bin;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) driveInputs(1'b0, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic sendSample(input laneIdxT pix, input binCodeT bin, input bit counted);
        driveInputs(1'b0, 1'b0, 1'b1, pix, bin);
        if (counted) begin
            addToModel(pix, bin);
        end
    endtask

    task automatic sendNoise(input int n);
        repeat (n) sendSample(laneIdxT'($urandom), binCodeT'($urandom), 1'b0);    // dropped
    endtask

    task automatic randomSamples(input int n);
        binCodeT bin;
        repeat (n) begin
            if ($urandom_range(0, 2) == 0) begin
                idleCycles($urandom_range(1, 3));
            end
            // narrow range now and then, so real peaks form
            if ($urandom_range(0, 3) == 0) begin
                bin = binCodeT'($urandom_range(0, 15));
            end else begin
                bin = binCodeT'($urandom);
            end
            sendSample(laneIdxT'($urandom), bin, 1'b1);
        end
    endtask

    task automatic burstSamples;
        binCodeT binA;
        binCodeT binB;
        for (int l = 0; l < LANE_NUM; l++) begin
            binA = binCodeT'($urandom);
            binB = binA + binCodeT'(1);
            repeat ($urandom_range(5, 12)) sendSample(laneIdxT'(l), binA, 1'b1);
            repeat (6) begin    // A B A B goes through the older forward path
                sendSample(laneIdxT'(l), binA, 1'b1);
                sendSample(laneIdxT'(l), binB, 1'b1);
            end
            idleCycles(2);
        end
    endtask

    task automatic beginFrame;
        int waited;
        driveInputs(1'b1, 1'b0, 1'b0, '0, '0);
        idleCycles(1);
        foreach (modelCount[l, b]) modelCount[l][b] = 0;
        waited = 0;
        @(negedge clk);
        while (busy !== 1'b1 && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (busy !== 1'b1) begin
            failNow("timeout: busy never rose after frameStart");
        end
        sendNoise(20);           // lanes still clearing
        idleCycles(BIN_NUM);     // well past the end of the sweep
    endtask

    task automatic endFrame;
        int startDone;
        int waited;
        binCodeT expBin;
        countT expCount;
        startDone = doneCount;
        gotLane.delete();
        gotBin.delete();
        gotCount.delete();
        driveInputs(1'b0, 1'b1, 1'b0, '0, '0);
        sendNoise(5);
        idleCycles(3);
        driveInputs(1'b1, 1'b0, 1'b0, '0, '0);    // readout running, must be ignored
        idleCycles(1);
        waited = 0;
        while (doneCount == startDone && waited < LANE_NUM * (BIN_NUM + 2) + 100) begin
            @(posedge clk);
            waited++;
        end
        if (doneCount == startDone) begin
            failNow("timeout: frameDone never pulsed after frameEnd");
        end
        if (gotLane.size() != LANE_NUM) begin
            failNow($sformatf("** Error at %0d ns: %0d peak results, expected %0d",
                $time, gotLane.size(), LANE_NUM));
        end
        for (int i = 0; i < LANE_NUM; i++) begin
            findPeak(i, expBin, expCount);
            checkPeak(gotLane[i], gotBin[i], gotCount[i], laneIdxT'(i), expBin, expCount);
        end
    endtask

    // outputs settle between edges
    always @(negedge clk) begin
        cycle++;
        if (peakValid === 1'b1) begin
            gotLane.push_back(peakLane);
            gotBin.push_back(peakBin);
            gotCount.push_back(peakCount);
            lastPeakCycle = cycle;
        end
        if (frameDone === 1'b1) begin
            checkFlag("busy during frameDone", busy, 1'b0);
            checkFlag("frameDone right after last peak", cycle == lastPeakCycle + 1, 1'b1);
            doneCount++;
        end
    end

    initial begin
        res = 1'b0;
        frameStart = 1'b0;
        frameEnd = 1'b0;
        sampleValid = 1'b0;
        samplePixel = '0;
        sampleBin = '0;
        void'($urandom(88869));
        repeat (2) @(posedge clk);
        res <= 1'b1;
        @(negedge clk);
        checkFlag("busy after reset", busy, 1'b0);
        checkFlag("peakValid after reset", peakValid, 1'b0);
        checkFlag("frameDone after reset", frameDone, 1'b0);

        beginFrame();    // empty frame
        endFrame();
        repeat (2) begin
            beginFrame();
            randomSamples(1000);
            endFrame();
        end
        beginFrame();
        burstSamples();
        endFrame();
        beginFrame();
        repeat (1100) sendSample(laneIdxT'(2), binCodeT'(77), 1'b1);
        randomSamples(200);
        endFrame();
        beginFrame();    // leftovers of the saturated bin would show here
        randomSamples(50);
        endFrame();

        $display("All checks passed");
        $finish;
    end

endmodule

/* vlog.f */
source/histConfigPkg.sv
source/histTypesPkg.sv
source/laneFeedIf.sv
source/laneDrainIf.sv
source/binMemory.sv
source/sampleRouter.sv
source/histogramLane.sv
source/peakReadout.sv
source/histogramTop.sv
bench/histogramBench.sv

/* runSim.sh */
#!/bin/sh
# build the histogram testbench with Verilator, run it and scan the log

rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal --top-module histogramBench -f vlog.f > build.log 2>&1 \
    || { cat build.log; echo "result: FAIL, Verilator build failed"; exit 1; }

./obj_dir/VhistogramBench > sim.log 2>&1 || echo "simulation exited with an error" >> sim.log
cat sim.log

grep -q "Checks failed" sim.log && { echo "result: FAIL"; exit 1; }
grep -q "All checks passed" sim.log || { echo "result: FAIL, run did not finish"; exit 1; }
echo "result: PASS"
